//--- retireUnit_testdata.txt
# A wait valid phys | C v0 log0 phys0 v1 log1 phys1 v2 log2 phys2 v3 log3 phys3 (decimal)
# I idles one cycle | R then 8 rows of expected phys for logical 4s..4s+3
# Drain the free list filled at reset.
A 0 1 32
A 0 1 33
A 0 1 34
A 0 1 35
A 0 1 36
A 0 1 37
A 0 1 38
A 0 1 39
A 0 1 40
A 0 1 41
A 0 1 42
A 0 1 43
A 0 1 44
A 0 1 45
A 0 1 46
A 0 1 47
A 0 1 48
A 0 1 49
A 0 1 50
A 0 1 51
A 0 1 52
A 0 1 53
A 0 1 54
A 0 1 55
A 0 1 56
A 0 1 57
A 0 1 58
A 0 1 59
A 0 1 60
A 0 1 61
A 0 1 62
A 0 1 63
A 0 0 0
# Single commits on distinct destinations free the identity mappings.
C 1 5 32 0 0 0 0 0 0 0 0 0
C 0 0 0 1 9 33 0 0 0 0 0 0
C 0 0 0 0 0 0 1 12 34 0 0 0
A 1 1 5
A 0 1 9
A 0 1 12
A 0 0 0
# Invalid lanes on the same destination free nothing.
C 1 7 35 0 0 0 0 7 36 0 7 37
A 1 1 7
A 0 0 0
I
# Lanes 0 and 2 share logical 5, lane 0 frees its own register.
C 1 5 36 1 9 39 1 5 37 1 20 38
A 1 1 36
A 0 1 33
A 0 1 32
A 0 1 20
A 0 0 0
# Lanes 0, 1 and 3 share logical 12, only lane 3 writes.
C 1 12 40 1 12 41 1 3 42 1 12 43
A 1 1 40
A 0 1 41
A 0 1 3
A 0 1 34
A 0 0 0
# Recovery walk over the committed table.
R
0 1 2 42
4 37 6 35
8 39 10 11
43 13 14 15
16 17 18 19
38 21 22 23
24 25 26 27
28 29 30 31
# Commits resume after the walk.
C 0 0 0 0 0 0 0 0 0 1 0 44
A 1 1 0
A 0 0 0

//--- src.f
amtPkg.sv
archMapStore.sv
retireLane.sv
freeListQueue.sv
retireUnit.sv
retireUnit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module retireUnit_tb -o retireUnitSim ||
  { echo "Verilator build failed"; exit 1; }
simOut=$(./obj_dir/retireUnitSim 2>&1)
echo "$simOut"
echo "$simOut" | grep -qx "TB PASSED" &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

//--- retireUnit_tb.sv
// Command-file testbench driving commits, allocations and recovery walks into the retirement unit.
module retireUnit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import amtPkg::*;

  localparam string DATA_FILE = "retireUnit_testdata.txt";  // Relative to project root.

  logic                clk = 1'b0;
  logic                reset;
  logic [COMMIT_W-1:0] commitValid;                 // Lane 3 youngest.
  logic [LOG_W-1:0]    commitLog [COMMIT_W];
  logic [PHYS_W-1:0]   commitPhys [COMMIT_W];
  logic                recoverFlag;
  logic                allocReady;
  logic                allocValid;
  logic [PHYS_W-1:0]   allocPhys;
  logic                recoverValid;
  logic [LOG_W-1:0]    recoverLog [COMMIT_W];
  logic [PHYS_W-1:0]   recoverPhys [COMMIT_W];
  int unsigned         cycleCount = 0;
  int unsigned         cycleLimit = 0;              // Zero until the file is sized.

  always #20 clk = ~clk;  // 40 ns period.

  retireUnit dut_i (
    .clk(clk), .reset(reset),
    .commitValid0_i(commitValid[0]), .commitValid1_i(commitValid[1]),
    .commitValid2_i(commitValid[2]), .commitValid3_i(commitValid[3]),
    .commitLog0_i(commitLog[0]), .commitLog1_i(commitLog[1]),
    .commitLog2_i(commitLog[2]), .commitLog3_i(commitLog[3]),
    .commitPhys0_i(commitPhys[0]), .commitPhys1_i(commitPhys[1]),
    .commitPhys2_i(commitPhys[2]), .commitPhys3_i(commitPhys[3]),
    .recoverFlag_i(recoverFlag), .allocReady_i(allocReady),
    .allocValid_o(allocValid), .allocPhys_o(allocPhys),
    .recoverValid_o(recoverValid),
    .recoverLog0_o(recoverLog[0]), .recoverLog1_o(recoverLog[1]),
    .recoverLog2_o(recoverLog[2]), .recoverLog3_o(recoverLog[3]),
    .recoverPhys0_o(recoverPhys[0]), .recoverPhys1_o(recoverPhys[1]),
    .recoverPhys2_o(recoverPhys[2]), .recoverPhys3_o(recoverPhys[3])
  );

  // ------------------------------------------------------------
  // Failure reporting and compares.
  // ------------------------------------------------------------
  task automatic stopOnFailure(input string what);
    $display("%s", what);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkPhys(input string name, input logic [PHYS_W-1:0] expVal,
                           input logic [PHYS_W-1:0] actVal);
    if (actVal !== expVal) begin
      stopOnFailure($sformatf("** Error at %0d ns: %s expected %0d, got %0d",
                              $time, name, expVal, actVal));
    end
  endtask

  task automatic checkLog(input string name, input logic [LOG_W-1:0] expVal,
                          input logic [LOG_W-1:0] actVal);
    if (actVal !== expVal) begin
      stopOnFailure($sformatf("** Error at %0d ns: %s expected %0d, got %0d",
                              $time, name, expVal, actVal));
    end
  endtask

  task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      stopOnFailure($sformatf("** Error at %0d ns: %s expected %0b, got %0b",
                              $time, name, expVal, actVal));
    end
  endtask

  // Cycle limit sized from the command file.
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
      stopOnFailure("simulation timed out");
    end
  end

  // ------------------------------------------------------------
  // Command file handling.
  // ------------------------------------------------------------
  task automatic openData(output int fd);
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      stopOnFailure("could not open the command file");
    end
  endtask

  // Total cycles of all commands in the file.
  task automatic sizeRun(output int unsigned total);
    int fd;
    int waitN;
    string line;
    total = 0;
    openData(fd);
    while ($fgets(line, fd) != 0) begin
      case (line[0])
        "A": if ($sscanf(line, "A %d", waitN) == 1) total += waitN + 1;
        "C", "I": total += 1;
        "R": total += RECOVER_STEPS + 2;  // Pulse, walk, end check.
        default: ;
      endcase
    end
    $fclose(fd);
  endtask

  // Wait for the rising edge and return every input to quiet.
  task automatic nextCycle();
    @(posedge clk);
    commitValid <= '0;
    recoverFlag <= 1'b0;
    allocReady  <= 1'b0;
  endtask

  task automatic runCommit(input string line);
    int v [COMMIT_W];
    int l [COMMIT_W];
    int p [COMMIT_W];
    if ($sscanf(line, "C %d %d %d %d %d %d %d %d %d %d %d %d",
                v[0], l[0], p[0], v[1], l[1], p[1],
                v[2], l[2], p[2], v[3], l[3], p[3]) != 12) begin
      stopOnFailure("malformed commit line in the command file");
    end
    nextCycle();
    for (int k = 0; k < COMMIT_W; k++) begin
      commitValid[k] <= (v[k] != 0);
      commitLog[k]   <= LOG_W'(l[k]);
      commitPhys[k]  <= PHYS_W'(p[k]);
    end
  endtask

  task automatic runAlloc(input string line);
    int waitN;
    int expValid;
    int expPhys;
    if ($sscanf(line, "A %d %d %d", waitN, expValid, expPhys) != 3) begin
      stopOnFailure("malformed allocation line in the command file");
    end
    repeat (waitN) nextCycle();  // Release latency.
    nextCycle();
    allocReady <= 1'b1;
    @(negedge clk);
    checkFlag("allocValid_o", expValid != 0, allocValid);
    if (expValid != 0) begin
      checkPhys("allocPhys_o", PHYS_W'(expPhys), allocPhys);
    end
  endtask

  task automatic runRecover(input int fd);
    int row [COMMIT_W];
    string line;
    nextCycle();
    recoverFlag <= 1'b1;  // One-cycle pulse.
    for (int s = 0; s < RECOVER_STEPS; s++) begin
      if ($fgets(line, fd) == 0 ||
          $sscanf(line, "%d %d %d %d", row[0], row[1], row[2], row[3]) != 4) begin
        stopOnFailure("missing or malformed recovery row in the command file");
      end
      nextCycle();
      @(negedge clk);
      checkFlag("recoverValid_o", 1'b1, recoverValid);
      for (int k = 0; k < COMMIT_W; k++) begin
        // Step s carries logical entries 4s to 4s+3.
        checkLog($sformatf("recoverLog%0d_o", k), LOG_W'(s * COMMIT_W + k), recoverLog[k]);
        checkPhys($sformatf("recoverPhys%0d_o", k), PHYS_W'(row[k]), recoverPhys[k]);
      end
    end
    nextCycle();
    @(negedge clk);
    checkFlag("recoverValid_o", 1'b0, recoverValid);  // Walk over.
  endtask

  // ------------------------------------------------------------
  // Main sequence.
  // ------------------------------------------------------------
  initial begin
    int fd;
    int unsigned runCycles;
    string line;
    reset       = 1'b1;
    commitValid = '0;
    commitLog   = '{default: '0};
    commitPhys  = '{default: '0};
    recoverFlag = 1'b0;
    allocReady  = 1'b0;
    sizeRun(runCycles);
    cycleLimit = 4 * runCycles + 50;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    openData(fd);
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment.
      case (line[0])
        "I": nextCycle();
        "C": runCommit(line);
        "A": runAlloc(line);
        "R": runRecover(fd);
        default: stopOnFailure("unknown command in the command file");
      endcase
    end
    $fclose(fd);
    nextCycle();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- retireUnit.sv
// Retirement top level joining the map table, commit lanes and free list.
module retireUnit (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      commitValid0_i,
  input  logic                      commitValid1_i,
  input  logic                      commitValid2_i,
  input  logic                      commitValid3_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog0_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog1_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog2_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog3_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys0_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys1_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys2_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys3_i,
  input  logic                      recoverFlag_i,
  input  logic                      allocReady_i,
  output logic                      allocValid_o,
  output logic [amtPkg::PHYS_W-1:0] allocPhys_o,
  output logic                      recoverValid_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog0_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog1_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog2_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog3_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys0_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys1_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys2_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys3_o
);
  import amtPkg::*;

  logic [PHYS_W-1:0]   commitPhys [COMMIT_W];  // Lane-indexed new registers.
  logic [PHYS_W-1:0]   oldMap [COMMIT_W];      // Table reads per lane.
  logic [COMMIT_W-1:0] writeEn;                // Lane write grants.
  logic [COMMIT_W-1:0] relValid;               // Registered releases.
  logic [PHYS_W-1:0]   relPhys [COMMIT_W];

  assign commitPhys = '{commitPhys0_i, commitPhys1_i, commitPhys2_i, commitPhys3_i};

  archMapStore uStore (
    .clk(clk), .reset(reset),
    .commitLog0_i(commitLog0_i), .commitLog1_i(commitLog1_i),
    .commitLog2_i(commitLog2_i), .commitLog3_i(commitLog3_i),
    .commitPhys0_i(commitPhys0_i), .commitPhys1_i(commitPhys1_i),
    .commitPhys2_i(commitPhys2_i), .commitPhys3_i(commitPhys3_i),
    .writeEn0_i(writeEn[0]), .writeEn1_i(writeEn[1]),
    .writeEn2_i(writeEn[2]), .writeEn3_i(writeEn[3]),
    .recoverFlag_i(recoverFlag_i),
    .oldMap0_o(oldMap[0]), .oldMap1_o(oldMap[1]),
    .oldMap2_o(oldMap[2]), .oldMap3_o(oldMap[3]),
    .recoverValid_o(recoverValid_o),
    .recoverLog0_o(recoverLog0_o), .recoverLog1_o(recoverLog1_o),
    .recoverLog2_o(recoverLog2_o), .recoverLog3_o(recoverLog3_o),
    .recoverPhys0_o(recoverPhys0_o), .recoverPhys1_o(recoverPhys1_o),
    .recoverPhys2_o(recoverPhys2_o), .recoverPhys3_o(recoverPhys3_o)
  );

  // Every lane sees the whole window to judge supersession.
  for (genvar k = 0; k < COMMIT_W; k++) begin : gLane
    retireLane #(.laneIdx(k)) uLane (
      .clk(clk), .reset(reset),
      .commitValid0_i(commitValid0_i), .commitValid1_i(commitValid1_i),
      .commitValid2_i(commitValid2_i), .commitValid3_i(commitValid3_i),
      .commitLog0_i(commitLog0_i), .commitLog1_i(commitLog1_i),
      .commitLog2_i(commitLog2_i), .commitLog3_i(commitLog3_i),
      .commitPhys_i(commitPhys[k]), .oldMap_i(oldMap[k]),
      .writeEn_o(writeEn[k]), .relValid_o(relValid[k]), .relPhys_o(relPhys[k])
    );
  end

  freeListQueue uFree (
    .clk(clk), .reset(reset),
    .relValid0_i(relValid[0]), .relValid1_i(relValid[1]),
    .relValid2_i(relValid[2]), .relValid3_i(relValid[3]),
    .relPhys0_i(relPhys[0]), .relPhys1_i(relPhys[1]),
    .relPhys2_i(relPhys[2]), .relPhys3_i(relPhys[3]),
    .allocReady_i(allocReady_i),
    .allocValid_o(allocValid_o), .allocPhys_o(allocPhys_o)
  );

endmodule

//--- freeListQueue.sv
// Circular free list with four compacted pushes and one pop per cycle.
module freeListQueue (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      relValid0_i,
  input  logic                      relValid1_i,
  input  logic                      relValid2_i,
  input  logic                      relValid3_i,
  input  logic [amtPkg::PHYS_W-1:0] relPhys0_i,
  input  logic [amtPkg::PHYS_W-1:0] relPhys1_i,
  input  logic [amtPkg::PHYS_W-1:0] relPhys2_i,
  input  logic [amtPkg::PHYS_W-1:0] relPhys3_i,
  input  logic                      allocReady_i,
  output logic                      allocValid_o,
  output logic [amtPkg::PHYS_W-1:0] allocPhys_o
);
  import amtPkg::*;

  logic [PHYS_W-1:0]     fifoMem [FREE_DEPTH];  // Free register slots.
  logic [FREE_PTR_W-1:0] headPtr;               // Oldest free entry.
  logic [FREE_PTR_W-1:0] tailPtr;               // Next slot to fill.
  logic [FREE_PTR_W:0]   count;                 // Occupancy from 0 to 32.
  logic [FREE_PTR_W:0]   nextCount;             // Occupancy after this edge.
  logic [FREE_PTR_W:0]   pushCnt;               // Valid releases this cycle.
  logic [COMMIT_W-1:0]   relValid;
  logic [PHYS_W-1:0]     relPhys [COMMIT_W];
  logic [FREE_PTR_W-1:0] slot [COMMIT_W];       // Compacted write slot per lane.
  logic                  popDo;                 // Pop that actually happens.

  assign relValid = {relValid3_i, relValid2_i, relValid1_i, relValid0_i};
  assign relPhys  = '{relPhys0_i, relPhys1_i, relPhys2_i, relPhys3_i};

  // ------------------------------------------------------------
  // Pack valid releases in lane order behind the tail.
  // ------------------------------------------------------------
  always_comb begin
    pushCnt = '0;
    for (int k = 0; k < COMMIT_W; k++) begin
      slot[k] = tailPtr + pushCnt[FREE_PTR_W-1:0];  // Skips invalid lanes.
      pushCnt = pushCnt + relValid[k];
    end
  end

  assign allocValid_o = (count != '0);
  assign allocPhys_o  = fifoMem[headPtr];
  assign popDo        = allocReady_i && allocValid_o;  // Pop on empty ignored.
  assign nextCount    = count + pushCnt - popDo;

  // ------------------------------------------------------------
  // Storage and pointers.
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      headPtr <= '0;
      tailPtr <= '0;  // Full, so tail wraps onto head.
      count   <= (FREE_PTR_W + 1)'(FREE_DEPTH);
      for (int i = 0; i < FREE_DEPTH; i++) begin
        fifoMem[i] <= PHYS_W'(NUM_LOG + i);  // Upper half of the file is free.
      end
    end else begin
      for (int k = 0; k < COMMIT_W; k++) begin
        if (relValid[k]) begin
          fifoMem[slot[k]] <= relPhys[k];
        end
      end
      tailPtr <= tailPtr + pushCnt[FREE_PTR_W-1:0];
      if (popDo) begin
        headPtr <= headPtr + 1'b1;
      end
      count <= nextCount;
    end
  end

  // Releases only follow allocations, so the list can never overfill.
  assert property (@(posedge clk) disable iff (reset)
    nextCount <= (FREE_PTR_W + 1)'(FREE_DEPTH));

endmodule

//--- retireLane.sv
// One commit lane with supersession check, write enable and release register.
module retireLane #(
  parameter int laneIdx = 0  // 0 is oldest, 3 youngest.
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      commitValid0_i,
  input  logic                      commitValid1_i,
  input  logic                      commitValid2_i,
  input  logic                      commitValid3_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog0_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog1_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog2_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog3_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys_i,
  input  logic [amtPkg::PHYS_W-1:0] oldMap_i,
  output logic                      writeEn_o,
  output logic                      relValid_o,
  output logic [amtPkg::PHYS_W-1:0] relPhys_o
);
  import amtPkg::*;

  logic [COMMIT_W-1:0] laneValid;           // Valid bits of the window.
  logic [LOG_W-1:0]    laneLog [COMMIT_W];  // Destinations of the window.
  logic                superseded;          // A younger lane owns our dest.
  logic [PHYS_W-1:0]   relNext;             // Register to hand back.

  assign laneValid = {commitValid3_i, commitValid2_i, commitValid1_i, commitValid0_i};
  assign laneLog   = '{commitLog0_i, commitLog1_i, commitLog2_i, commitLog3_i};

  // ------------------------------------------------------------
  // Youngest committer wins the table entry.
  // ------------------------------------------------------------
  always_comb begin
    superseded = 1'b0;
    for (int j = laneIdx + 1; j < COMMIT_W; j++) begin
      if (laneValid[j] && (laneLog[j] == laneLog[laneIdx])) begin
        superseded = 1'b1;  // Only valid younger lanes count.
      end
    end
  end

  assign writeEn_o = laneValid[laneIdx] && !superseded;

  // A superseded commit is dead on arrival, so its own register frees.
  assign relNext = superseded ? commitPhys_i : oldMap_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      relValid_o <= 1'b0;
    end else begin
      relValid_o <= laneValid[laneIdx];  // Every valid commit frees one.
    end
  end

  always_ff @(posedge clk) begin
    relPhys_o <= relNext;
  end

  // A surviving commit never frees the register it just installed.
  assert property (@(posedge clk) disable iff (reset)
    relValid_o && !$past(superseded) |-> relPhys_o != $past(commitPhys_i));

endmodule

//--- archMapStore.sv
// Architectural map table with commit read/write ports and recovery walker.
module archMapStore (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [amtPkg::LOG_W-1:0]  commitLog0_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog1_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog2_i,
  input  logic [amtPkg::LOG_W-1:0]  commitLog3_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys0_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys1_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys2_i,
  input  logic [amtPkg::PHYS_W-1:0] commitPhys3_i,
  input  logic                      writeEn0_i,
  input  logic                      writeEn1_i,
  input  logic                      writeEn2_i,
  input  logic                      writeEn3_i,
  input  logic                      recoverFlag_i,
  output logic [amtPkg::PHYS_W-1:0] oldMap0_o,
  output logic [amtPkg::PHYS_W-1:0] oldMap1_o,
  output logic [amtPkg::PHYS_W-1:0] oldMap2_o,
  output logic [amtPkg::PHYS_W-1:0] oldMap3_o,
  output logic                      recoverValid_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog0_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog1_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog2_o,
  output logic [amtPkg::LOG_W-1:0]  recoverLog3_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys0_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys1_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys2_o,
  output logic [amtPkg::PHYS_W-1:0] recoverPhys3_o
);
  import amtPkg::*;

  logic [PHYS_W-1:0]         mapTable [NUM_LOG];   // Committed mapping.
  logic [LOG_W-1:0]          wrLog [COMMIT_W];     // Write addresses by lane.
  logic [PHYS_W-1:0]         wrPhys [COMMIT_W];    // Write data by lane.
  logic [COMMIT_W-1:0]       wrEn;                 // Youngest-wins enables.
  logic                      wrClash;              // Two writes on one entry.
  logic                      recActive;            // Walk in progress.
  logic [RECOVER_STEP_W-1:0] recStep;              // Current walk step.
  logic [LOG_W-1:0]          recBase;              // First entry of this step.

  assign wrLog  = '{commitLog0_i, commitLog1_i, commitLog2_i, commitLog3_i};
  assign wrPhys = '{commitPhys0_i, commitPhys1_i, commitPhys2_i, commitPhys3_i};
  assign wrEn   = {writeEn3_i, writeEn2_i, writeEn1_i, writeEn0_i};

  // ------------------------------------------------------------
  // Old mapping reads before this cycle's writes land.
  // ------------------------------------------------------------
  assign oldMap0_o = mapTable[commitLog0_i];
  assign oldMap1_o = mapTable[commitLog1_i];
  assign oldMap2_o = mapTable[commitLog2_i];
  assign oldMap3_o = mapTable[commitLog3_i];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_LOG; i++) begin
        mapTable[i] <= PHYS_W'(i);  // Identity map out of reset.
      end
    end else begin
      for (int k = 0; k < COMMIT_W; k++) begin
        if (wrEn[k]) begin
          mapTable[wrLog[k]] <= wrPhys[k];  // Superseded lanes are gated off.
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Recovery walker streaming four entries per step.
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      recActive <= 1'b0;
      recStep   <= '0;
    end else if (recoverFlag_i) begin
      recActive <= 1'b1;  // Step 0 shows next cycle.
      recStep   <= '0;
    end else if (recActive) begin
      if (recStep == RECOVER_STEP_W'(RECOVER_STEPS - 1)) begin
        recActive <= 1'b0;  // Last step done.
      end
      recStep <= recStep + 1'b1;
    end
  end

  assign recBase        = LOG_W'(recStep * COMMIT_W);
  assign recoverValid_o = recActive;
  assign recoverLog0_o  = recBase;
  assign recoverLog1_o  = recBase + LOG_W'(1);
  assign recoverLog2_o  = recBase + LOG_W'(2);
  assign recoverLog3_o  = recBase + LOG_W'(3);
  assign recoverPhys0_o = mapTable[recoverLog0_o];
  assign recoverPhys1_o = mapTable[recoverLog1_o];
  assign recoverPhys2_o = mapTable[recoverLog2_o];
  assign recoverPhys3_o = mapTable[recoverLog3_o];

  always_comb begin
    wrClash = 1'b0;
    for (int a = 0; a < COMMIT_W; a++) begin
      for (int b = a + 1; b < COMMIT_W; b++) begin
        if (wrEn[a] && wrEn[b] && (wrLog[a] == wrLog[b])) begin
          wrClash = 1'b1;
        end
      end
    end
  end

  // Lane supersession must leave one writer per entry.
  assert property (@(posedge clk) disable iff (reset) !wrClash);

  // No commits may land while the table is being streamed out.
  assert property (@(posedge clk) disable iff (reset) recActive |-> (wrEn == '0));

endmodule

//--- amtPkg.sv
// Register file sizes, commit width, free list and recovery walk widths.
package amtPkg;

  // ------------------------------------------------------------
  // Register files.
  // ------------------------------------------------------------
  localparam int NUM_LOG  = 32;  // Logical registers.
  localparam int LOG_W    = 5;   // Logical index width.
  localparam int NUM_PHYS = 64;  // Physical registers.
  localparam int PHYS_W   = 6;   // Physical index width.

  // ------------------------------------------------------------
  // Retirement.
  // ------------------------------------------------------------
  localparam int COMMIT_W = 4;  // Commits per cycle with lane 3 youngest.

  // Registers not held by the committed map start out free.
  localparam int FREE_DEPTH = NUM_PHYS - NUM_LOG;  // Free list slots.
  localparam int FREE_PTR_W = 5;                   // Head and tail width.

  // ------------------------------------------------------------
  // Recovery walk.
  // ------------------------------------------------------------
  localparam int RECOVER_STEPS  = NUM_LOG / COMMIT_W;  // Cycles per walk.
  localparam int RECOVER_STEP_W = 3;                   // Step counter width.

endpackage
